/* otp_lci_pkg.sv */
package otp_lci_pkg;

  ////////////////////////////////////////
  // Native OTP geometry
  ////////////////////////////////////////

  // One native fuse word
  parameter int OtpWidth = 16;
  // Word address into the macro
  parameter int OtpAddrWidth = 10;

  // Error codes shared by the macro and the partition
  typedef enum logic [2:0] {
    NoError              = 3'h0,
    // Write tried to clear a fuse that is already blown
    MacroWriteBlankError = 3'h4,
    // Escalation, glitched FSM or counter mismatch
    FsmStateError        = 3'h7
  } otp_err_e;

  // Macro command
  typedef enum logic {
    Read  = 1'b0,
    Write = 1'b1
  } otp_cmd_e;

  // Multi-bit escalation signal
  typedef enum logic [3:0] {
    On  = 4'b0101,
    Off = 4'b1010
  } lc_tx_t;

  ////////////////////////////////////////
  // Macro request and response
  ////////////////////////////////////////

  typedef struct packed {
    logic                    req;
    otp_cmd_e                cmd;
    logic [OtpAddrWidth-1:0] addr;
    logic [OtpWidth-1:0]     wdata;
  } otp_req_t;

  typedef struct packed {
    logic     gnt;
    logic     rvalid;
    otp_err_e err;
  } otp_rsp_t;

  // Anything but Off is treated as asserted
  function automatic logic lc_tx_test_true_loose(lc_tx_t val);
    return val != Off;
  endfunction

  // Bits needed to hold values 0 .. n-1, never less than one
  function automatic int vbits(int n);
    return (n <= 1) ? 1 : $clog2(n);
  endfunction

endpackage

/* otp_lci_word_cnt.sv */
`timescale 1ns/1ps

module otp_lci_word_cnt #(
  parameter int NumWords = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     clr_i,
  input  logic                                     incr_i,
  output logic [otp_lci_pkg::vbits(NumWords)-1:0]  cnt_o,
  output logic                                     err_o
);
  import otp_lci_pkg::*;

  localparam int CntWidth = vbits(NumWords);

  // Primary copy counts up from zero
  logic [CntWidth-1:0] up_q;
  // Shadow copy counts down from all ones
  logic [CntWidth-1:0] dn_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      up_q <= '0;
      dn_q <= '1;
    end else if (clr_i) begin
      up_q <= '0;
      dn_q <= '1;
    end else if (incr_i) begin
      up_q <= up_q + 1'b1;
      dn_q <= dn_q - 1'b1;
    end
  end

  assign cnt_o = up_q;

  // Shadow must always be the complement of the primary copy
  // A single flipped flop shows up here
  assign err_o = (up_q != ~dn_q);

endmodule

/* otp_lci_fsm.sv */
`timescale 1ns/1ps

module otp_lci_fsm #(
  parameter int NumWords   = 4,
  parameter int PartOffset = 8
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      lci_en_i,
  input  otp_lci_pkg::lc_tx_t                       escalate_en_i,
  // Transition request from the life cycle controller
  input  logic                                      lc_req_i,
  input  logic [NumWords*otp_lci_pkg::OtpWidth-1:0] lc_data_i,
  output logic                                      lc_ack_o,
  output logic                                      lc_err_o,
  // Sticky partition error code
  output otp_lci_pkg::otp_err_e                     error_o,
  output logic                                      fsm_err_o,
  output logic                                      lci_prog_idle_o,
  // Macro side
  output otp_lci_pkg::otp_req_t                     otp_req_o,
  input  otp_lci_pkg::otp_rsp_t                     otp_rsp_i
);
  import otp_lci_pkg::*;

  localparam int CntWidth = vbits(NumWords);
  localparam logic [CntWidth-1:0] LastWord = CntWidth'(NumWords - 1);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  // Sparse encoding, minimum Hamming distance 5
  typedef enum logic [8:0] {
    ResetSt     = 9'b000101011,
    IdleSt      = 9'b110011110,
    WriteSt     = 9'b101010001,
    WriteWaitSt = 9'b010000000,
    ErrorSt     = 9'b011111101
  } state_e;

  state_e              state_d, state_q;
  otp_err_e            error_d, error_q;
  logic                cnt_clr, cnt_incr, cnt_err;
  logic [CntWidth-1:0] cnt;
  logic                req;
  otp_cmd_e            cmd;

  assign error_o = error_q;

  always_comb begin : p_fsm
    state_d         = state_q;
    error_d         = error_q;
    cnt_clr         = 1'b0;
    cnt_incr        = 1'b0;
    req             = 1'b0;
    cmd             = Read;
    lc_ack_o        = 1'b0;
    lc_err_o        = 1'b0;
    fsm_err_o       = 1'b0;
    lci_prog_idle_o = 1'b0;

    unique case (state_q)
      // Hold until the partition is enabled
      ResetSt: begin
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      // Ready for a transition
      IdleSt: begin
        lci_prog_idle_o = 1'b1;
        if (lc_req_i) begin
          state_d = WriteSt;
          cnt_clr = 1'b1;
        end
      end
      // Present the current word until the macro takes it
      WriteSt: begin
        req = 1'b1;
        cmd = Write;
        if (otp_rsp_i.gnt) begin
          state_d = WriteWaitSt;
        end
      end
      // Collect the response of the word in flight
      WriteWaitSt: begin
        if (otp_rsp_i.rvalid) begin
          // Keep the latest macro error but carry on with the rest
          if (otp_rsp_i.err != NoError) begin
            error_d = otp_rsp_i.err;
          end
          if (cnt == LastWord) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            // Any failed word ends in the error state
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_incr = 1'b1;
            state_d  = WriteSt;
          end
        end
      end
      // Terminal, only reset leaves it
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Glitched encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation and counter faults override everything
    if (lc_tx_test_true_loose(escalate_en_i) || cnt_err) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////////////////////////
  // Word counter and macro request
  ////////////////////////////////////////

  otp_lci_word_cnt #(
    .NumWords(NumWords)
  ) u_word_cnt (
    .clk_i,
    .rst_ni,
    .clr_i (cnt_clr),
    .incr_i(cnt_incr),
    .cnt_o (cnt),
    .err_o (cnt_err)
  );

  logic [NumWords-1:0][OtpWidth-1:0] data;
  assign data = lc_data_i;

  // Word address is partition base plus word index
  // Write data is zero whenever no request is out
  assign otp_req_o = '{
    req:   req,
    cmd:   cmd,
    addr:  OtpAddrWidth'(PartOffset) + OtpAddrWidth'(cnt),
    wdata: req ? data[cnt] : '0
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

endmodule

/* otp_fuse_array.sv */
`timescale 1ns/1ps

module otp_fuse_array #(
  parameter int ArrayWords   = 32,
  parameter int NumWords     = 4,
  parameter int PartOffset   = 8,
  parameter int WriteLatency = 3
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  otp_lci_pkg::otp_req_t                     otp_req_i,
  output otp_lci_pkg::otp_rsp_t                     otp_rsp_o,
  // Live view of the life cycle partition
  output logic [NumWords*otp_lci_pkg::OtpWidth-1:0] part_data_o
);
  import otp_lci_pkg::*;

  localparam int LatWidth = vbits(WriteLatency);
  localparam int IdxWidth = vbits(ArrayWords);

  ////////////////////////////////////////
  // Fuse storage
  ////////////////////////////////////////

  // All fuses blank after reset
  logic [ArrayWords-1:0][OtpWidth-1:0] fuse_q;

  logic                gnt;
  logic                in_range;
  logic [IdxWidth-1:0] idx;
  logic [OtpWidth-1:0] old_word;
  logic                blank_err;

  // One write in flight at most
  logic                busy_q;
  logic [LatWidth-1:0] lat_q;
  otp_err_e            err_q;
  logic                rvalid;

  assign gnt      = otp_req_i.req && !busy_q;
  assign in_range = int'(otp_req_i.addr) < ArrayWords;
  assign idx      = otp_req_i.addr[IdxWidth-1:0];
  assign old_word = in_range ? fuse_q[idx] : '0;

  // A blown fuse that the new word leaves at zero cannot be cleared
  assign blank_err = |(old_word & ~otp_req_i.wdata);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_macro
    if (!rst_ni) begin
      fuse_q <= '0;
      busy_q <= 1'b0;
      lat_q  <= '0;
      err_q  <= NoError;
    end else if (gnt) begin
      busy_q <= 1'b1;
      // Counts down to the rvalid cycle
      lat_q  <= LatWidth'(WriteLatency - 1);
      err_q  <= NoError;
      if (otp_req_i.cmd == Write && in_range) begin
        if (blank_err) begin
          err_q <= MacroWriteBlankError;
        end else begin
          fuse_q[idx] <= old_word | otp_req_i.wdata;
        end
      end
    end else if (busy_q) begin
      if (lat_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        lat_q <= lat_q - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Response and readout
  ////////////////////////////////////////

  // Fires WriteLatency cycles after the grant cycle
  assign rvalid = busy_q && (lat_q == '0);

  assign otp_rsp_o = '{
    gnt:    gnt,
    rvalid: rvalid,
    err:    rvalid ? err_q : NoError
  };

  for (genvar i = 0; i < NumWords; i++) begin : g_part
    assign part_data_o[i*OtpWidth +: OtpWidth] = fuse_q[PartOffset + i];
  end

endmodule

/* otp_lci_top.sv */
`timescale 1ns/1ps

module otp_lci_top #(
  parameter int NumWords     = 4,
  parameter int PartOffset   = 8,
  parameter int WriteLatency = 3,
  parameter int ArrayWords   = 32
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      lci_en_i,
  input  otp_lci_pkg::lc_tx_t                       escalate_en_i,
  input  logic                                      lc_req_i,
  input  logic [NumWords*otp_lci_pkg::OtpWidth-1:0] lc_data_i,
  output logic                                      lc_ack_o,
  output logic                                      lc_err_o,
  output otp_lci_pkg::otp_err_e                     error_o,
  output logic                                      fsm_err_o,
  output logic                                      lci_prog_idle_o,
  output logic [NumWords*otp_lci_pkg::OtpWidth-1:0] part_data_o
);
  import otp_lci_pkg::*;

  // Link between the programming FSM and the macro model
  otp_req_t otp_req;
  otp_rsp_t otp_rsp;

  otp_lci_fsm #(
    .NumWords  (NumWords),
    .PartOffset(PartOffset)
  ) u_lci (
    .clk_i,
    .rst_ni,
    .lci_en_i,
    .escalate_en_i,
    .lc_req_i,
    .lc_data_i,
    .lc_ack_o,
    .lc_err_o,
    .error_o,
    .fsm_err_o,
    .lci_prog_idle_o,
    .otp_req_o(otp_req),
    .otp_rsp_i(otp_rsp)
  );

  otp_fuse_array #(
    .ArrayWords  (ArrayWords),
    .NumWords    (NumWords),
    .PartOffset  (PartOffset),
    .WriteLatency(WriteLatency)
  ) u_fuse (
    .clk_i,
    .rst_ni,
    .otp_req_i(otp_req),
    .otp_rsp_o(otp_rsp),
    .part_data_o
  );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HalfPeriod  = 4,
  parameter int ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Power-on reset, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* tb_otp_lci.sv */
`timescale 1ns/1ps

module tb_otp_lci;
  import otp_lci_pkg::*;

  localparam int NumWords   = 4;
  localparam int DataWidth  = NumWords * OtpWidth;
  localparam int AckTimeout = 200;
  // Word that gets a cleared fuse in the blank-check test
  localparam int BlankWord  = 2;

  logic                 clk;
  logic                 rst_n_gen;
  logic                 tb_rst_n;
  logic                 rst_n;
  logic                 lci_en_i;
  lc_tx_t               escalate_en_i;
  logic                 lc_req_i;
  logic [DataWidth-1:0] lc_data_i;
  logic                 lc_ack_o;
  logic                 lc_err_o;
  otp_err_e             error_o;
  logic                 fsm_err_o;
  logic                 lci_prog_idle_o;
  logic [DataWidth-1:0] part_data_o;

  // Expected fuse contents of the partition
  logic [DataWidth-1:0] ref_img;
  int                   err_cnt;
  int                   timeout_cnt;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n_gen)
  );

  // Second reset source for the escalation test
  assign rst_n = rst_n_gen & tb_rst_n;

  otp_lci_top u_otp_lci_top (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .lci_en_i       (lci_en_i),
    .escalate_en_i  (escalate_en_i),
    .lc_req_i       (lc_req_i),
    .lc_data_i      (lc_data_i),
    .lc_ack_o       (lc_ack_o),
    .lc_err_o       (lc_err_o),
    .error_o        (error_o),
    .fsm_err_o      (fsm_err_o),
    .lci_prog_idle_o(lci_prog_idle_o),
    .part_data_o    (part_data_o)
  );

  ////////////////////////////////////////
  // Protocol properties
  ////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // No ack outside a pending transition
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) lc_ack_o |-> lc_req_i)
    else report_mismatch("lc_ack_o high without lc_req_i");

  // Ack is a single-cycle pulse
  ack_is_pulse: assert property (@(posedge clk) disable iff (!rst_n) lc_ack_o |=> !lc_ack_o)
    else report_mismatch("lc_ack_o longer than one cycle");

  ack_with_err: assert property (@(posedge clk) disable iff (!rst_n) lc_err_o |-> lc_ack_o)
    else report_mismatch("lc_err_o without lc_ack_o");

  // Error state is never idle
  no_idle_in_err: assert property (@(posedge clk) disable iff (!rst_n)
                                   (error_o != NoError) |-> !lci_prog_idle_o)
    else report_mismatch("lci_prog_idle_o high with an error recorded");

  ////////////////////////////////////////
  // Reference model and stimulus
  ////////////////////////////////////////

  function automatic logic [DataWidth-1:0] rand_data();
    return {$urandom(), $urandom()};
  endfunction

  // Word that would clear a blown fuse keeps its old value
  // Returns 1 if any word is refused
  function automatic logic apply_ref(input logic [DataWidth-1:0] data);
    logic [OtpWidth-1:0] old_w;
    logic [OtpWidth-1:0] new_w;
    logic                refused;
    refused = 1'b0;
    for (int i = 0; i < NumWords; i++) begin
      old_w = ref_img[i*OtpWidth +: OtpWidth];
      new_w = data[i*OtpWidth +: OtpWidth];
      if ((old_w & ~new_w) != '0) begin
        refused = 1'b1;
      end else begin
        ref_img[i*OtpWidth +: OtpWidth] = old_w | new_w;
      end
    end
    return refused;
  endfunction

  // Holds the request until ack or timeout, called on a falling edge
  task automatic run_transition(input logic [DataWidth-1:0] data,
                                output logic acked, output logic err_seen);
    int cycles;
    cycles    = 0;
    acked     = 1'b0;
    err_seen  = 1'b0;
    lc_data_i = data;
    lc_req_i  = 1'b1;
    while (!acked && cycles < AckTimeout) begin
      @(negedge clk);
      cycles++;
      if (lc_ack_o) begin
        acked    = 1'b1;
        err_seen = lc_err_o;
      end
    end
    // Request stays up over the edge that samples the ack
    if (acked) begin
      @(negedge clk);
    end
    lc_req_i = 1'b0;
  endtask

  // Transition that must be acknowledged, checked against the reference image
  task automatic expect_ack(input logic [DataWidth-1:0] data);
    logic     exp_err;
    logic     acked;
    logic     err_seen;
    otp_err_e exp_code;
    exp_err  = apply_ref(data);
    exp_code = exp_err ? MacroWriteBlankError : NoError;
    run_transition(data, acked, err_seen);
    if (!acked) begin
      $display("Timeout: no acknowledge within %0d cycles", AckTimeout);
      timeout_cnt++;
    end else begin
      assert (err_seen == exp_err)
        else report_mismatch($sformatf("lc_err_o %0b, expected %0b", err_seen, exp_err));
    end
    // Error register took its value on the ack edge
    assert (part_data_o == ref_img)
      else report_mismatch($sformatf("part_data_o %h, expected %h", part_data_o, ref_img));
    assert (error_o == exp_code)
      else report_mismatch($sformatf("error_o %s, expected %s", error_o.name(),
                                     exp_code.name()));
  endtask

  // Request in the error state, must run into its timeout
  task automatic expect_no_ack(input logic [DataWidth-1:0] data);
    logic acked;
    logic err_seen;
    run_transition(data, acked, err_seen);
    assert (!acked)
      else report_mismatch("acknowledge given in the error state");
    assert (!lci_prog_idle_o)
      else report_mismatch("lci_prog_idle_o high in the error state");
  endtask

  task automatic reset_and_enable();
    int cycles;
    cycles = 0;
    tb_rst_n = 1'b0;
    lci_en_i = 1'b0;
    repeat (8) @(negedge clk);
    tb_rst_n = 1'b1;
    ref_img  = '0;
    @(negedge clk);
    lci_en_i = 1'b1;
    while (!lci_prog_idle_o && cycles < AckTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!lci_prog_idle_o) begin
      $display("Timeout: FSM did not reach idle after enable");
      timeout_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [DataWidth-1:0] data;
    lc_tx_t               esc;
    int                   cycles;
    err_cnt       = 0;
    timeout_cnt   = 0;
    cycles        = 0;
    ref_img       = '0;
    tb_rst_n      = 1'b1;
    lci_en_i      = 1'b0;
    escalate_en_i = Off;
    lc_req_i      = 1'b0;
    lc_data_i     = '0;
    void'($urandom(32'h61a4_0a74));

    // Wait for the power-on reset to end
    while (rst_n !== 1'b1 && cycles < 50) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeout_cnt++;
    end
    @(negedge clk);

    // Reset values, enable not yet given
    assert (!lc_ack_o && !lc_err_o && !fsm_err_o && !lci_prog_idle_o)
      else report_mismatch("control outputs not 0 after reset");
    assert (error_o == NoError && part_data_o == '0)
      else report_mismatch("error_o or part_data_o not clear after reset");
    lci_en_i = 1'b1;
    @(negedge clk);
    assert (lci_prog_idle_o)
      else report_mismatch("lci_prog_idle_o not set one cycle after enable");

    // First transition on a blank partition
    expect_ack(rand_data());

    // Superset of the first image, fuse under test is blown here
    data = ref_img | rand_data();
    data[BlankWord*OtpWidth] = 1'b1;
    expect_ack(data);

    // Clear one blown fuse while the other words add bits
    data = ref_img | rand_data();
    data[BlankWord*OtpWidth] = 1'b0;
    expect_ack(data);
    expect_no_ack(ref_img | rand_data());

    // Escalation after a fresh reset
    reset_and_enable();
    esc = lc_tx_t'($urandom_range(15, 0));
    if (esc == Off) begin
      esc = On;
    end
    escalate_en_i = esc;
    cycles = 0;
    while (!fsm_err_o && cycles < AckTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!fsm_err_o) begin
      $display("Timeout: no fsm_err_o after escalation");
      timeout_cnt++;
    end
    @(negedge clk);
    escalate_en_i = Off;
    assert (error_o == FsmStateError)
      else report_mismatch($sformatf("error_o %s after escalation", error_o.name()));
    expect_no_ack(rand_data());

    $display("Checks failed: %0d, timeouts: %0d", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
otp_lci_pkg.sv
otp_lci_word_cnt.sv
otp_lci_fsm.sv
otp_fuse_array.sv
otp_lci_top.sv
tb_clk_gen.sv
tb_otp_lci.sv

/* Bender.yml */
package:
  name: otp_lci

sources:
  - files:
      - otp_lci_pkg.sv
      - otp_lci_word_cnt.sv
      - otp_lci_fsm.sv
      - otp_fuse_array.sv
      - otp_lci_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_otp_lci.sv
